// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build tb_rvv with Verilator and run it, output in sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rvv -f vlog.f -Mdir obj_dir
	./obj_dir/Vtb_rvv | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "run failed, see sim.log"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || { echo "run ended early, see sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_mem_model.sv
module tb_mem_model (
	input logic clk,
	input logic resetn,
	input logic req_i,
	input rvv_pkg::mem_req_t req_data_i,
	output logic done_o,
	output logic [31:0] rdata_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import rvv_pkg::*;

	logic [7:0] mem_bytes [256];
	logic written [256]; // set by every stored byte
	logic [31:0] lfsr_q;
	logic [2:0] delay_q;
	logic pending_q;
	mem_req_t cur_q;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic answer(input mem_req_t r);
		logic [7:0] base;
		base = {r.addr[7:2], 2'b00}; // word holding the addressed lanes
		done_o <= 1'b1;
		rdata_o <= {mem_bytes[base + 3], mem_bytes[base + 2], mem_bytes[base + 1], mem_bytes[base]};
		for (int i = 0; i < 4; i++) begin
			if (r.store && r.strb[i]) begin
				mem_bytes[base + i] <= r.wdata[8*i +: 8];
				written[base + i] <= 1'b1;
			end
		end
	endtask

	initial begin
		done_o <= 1'b0;
		rdata_o <= '0;
		lfsr_q <= 32'd83803;
		pending_q <= 1'b0;
		for (int a = 0; a < 256; a++) begin
			mem_bytes[a] <= 8'(a) ^ 8'h5a; // pattern over the whole address
			written[a] <= 1'b0;
		end
	end

	always @(posedge clk) begin : respond
		logic [31:0] step1;
		logic [2:0] delay;
		done_o <= 1'b0;
		if (!resetn) begin
			pending_q <= 1'b0;
		end else if (req_i) begin
			step1 = lfsr_step(lfsr_q);
			delay = {1'b0, step1[0], lfsr_q[0]} + 3'd1; // two bits give 1 to 4 cycles
			lfsr_q <= lfsr_step(step1);
			if (delay == 3'd1) begin
				answer(req_data_i);
			end else begin
				cur_q <= req_data_i;
				delay_q <= delay - 3'd1;
				pending_q <= 1'b1;
			end
		end else if (pending_q) begin
			delay_q <= delay_q - 3'd1;
			if (delay_q == 3'd1) begin
				answer(cur_q);
				pending_q <= 1'b0;
			end
		end
	end

endmodule

// File: dv/tb_rvv.sv
module tb_rvv;
	timeunit 1ns;
	timeprecision 100ps;
	import rvv_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000; // 3 memory tests x 16 elements x 6 cycles with wide margin
	localparam int LIMIT = 100; // cycles granted to one instruction

	logic clk, resetn, pcpi_valid, pcpi_wr, pcpi_wait, pcpi_ready, pcpi_trap, pcpi_is_rvv;
	logic [31:0] pcpi_insn, pcpi_rs1, pcpi_rs2, pcpi_rd, mem_rdata;
	logic mem_req, mem_done, mem_op;
	logic got_ready, got_trap, got_wr, saw_rvv;
	logic [31:0] got_rd;
	mem_req_t mem_req_data;
	mem_req_t req_log[$]; // every request seen on the memory port
	int errors, tests_run, tests_failed, cycle_count, resp_cycles, wait_drops;

	rvv_coproc UUT (.clk(clk), .resetn(resetn), .pcpi_valid_i(pcpi_valid),
		.pcpi_insn_i(pcpi_insn), .pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2), .pcpi_wr_o(pcpi_wr),
		.pcpi_rd_o(pcpi_rd), .pcpi_wait_o(pcpi_wait), .pcpi_ready_o(pcpi_ready),
		.pcpi_trap_o(pcpi_trap), .pcpi_is_rvv_o(pcpi_is_rvv), .mem_req_o(mem_req),
		.mem_req_data_o(mem_req_data), .mem_done_i(mem_done), .mem_rdata_i(mem_rdata),
		.mem_op_o(mem_op));

	tb_mem_model u_mem (.clk(clk), .resetn(resetn), .req_i(mem_req), .req_data_i(mem_req_data),
		.done_o(mem_done), .rdata_o(mem_rdata));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
		errors++;
	endtask

	task automatic failure(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	always @(posedge clk) begin
		if (mem_req) begin
			req_log.push_back(mem_req_data);
			if (!mem_op)
				failure("mem_req_o raised while mem_op_o was low");
		end
	end

	function automatic logic [31:0] vsetvli_insn(input logic [10:0] vtype);
		return {1'b0, vtype, 5'd11, 3'b111, 5'd10, OPC_V}; // rd x10, rs1 x11
	endfunction

	function automatic logic [31:0] vsetivli_insn(input logic [4:0] uimm, input logic [9:0] vtype);
		return {2'b11, vtype, uimm, 3'b111, 5'd10, OPC_V};
	endfunction

	function automatic logic [31:0] vsetvl_insn();
		return {7'b1000000, 5'd12, 5'd11, 3'b111, 5'd10, OPC_V};
	endfunction

	// unit stride, unmasked, base in x11
	function automatic logic [31:0] vmem_insn(input logic store, input logic [2:0] width,
			input logic [4:0] vd);
		return {12'h020, 5'd11, width, vd, store ? OPC_STORE_FP : OPC_LOAD_FP};
	endfunction

	// holds the instruction until ready, trap or the limit
	task automatic issue(input logic [31:0] insn, input logic [31:0] rs1, input logic [31:0] rs2,
			input int limit);
		got_ready = 1'b0;
		got_trap = 1'b0;
		saw_rvv = 1'b0;
		wait_drops = 0;
		resp_cycles = 0;
		@(posedge clk);
		pcpi_valid <= 1'b1;
		pcpi_insn <= insn;
		pcpi_rs1 <= rs1;
		pcpi_rs2 <= rs2;
		while (!got_ready && !got_trap && resp_cycles < limit) begin
			@(posedge clk);
			resp_cycles++;
			saw_rvv = saw_rvv | pcpi_is_rvv;
			got_ready = pcpi_ready;
			got_trap = pcpi_trap;
			got_wr = pcpi_wr;
			got_rd = pcpi_rd;
			if (resp_cycles > 1 && !pcpi_ready && !pcpi_trap && !(pcpi_wait && mem_op))
				wait_drops++;
		end
		pcpi_valid <= 1'b0;
	endtask

	task automatic config_result(input int exp_vl);
		if (!got_ready || !got_wr)
			failure("configuration gave no ready with pcpi_wr_o");
		if (resp_cycles != 2)
			mismatch("pcpi_ready_o latency", 2, resp_cycles);
		if (got_rd != exp_vl)
			mismatch("pcpi_rd_o", exp_vl, got_rd);
	endtask

	// element n sits at base plus n element sizes
	task automatic mem_result(input int exp_reqs, input int first, input logic store,
			input logic [31:0] base, input int elem_bytes);
		mem_req_t r;
		if (!got_ready)
			failure("memory instruction gave no ready");
		if (req_log.size() - first != exp_reqs)
			mismatch("mem_req_o count", exp_reqs, req_log.size() - first);
		if (wait_drops != 0)
			failure("pcpi_wait_o or mem_op_o dropped during a memory instruction");
		for (int n = 0; n < req_log.size() - first; n++) begin
			r = req_log[first + n];
			if (r.addr != base + n * elem_bytes)
				mismatch("mem_req_data_o.addr", base + n * elem_bytes, r.addr);
			if (r.store != store)
				mismatch("mem_req_data_o.store", store, r.store);
		end
	endtask

	task automatic trap_result(input int first);
		if (!got_trap || got_ready)
			failure("expected pcpi_trap_o without pcpi_ready_o");
		if (resp_cycles != 2)
			mismatch("pcpi_trap_o latency", 2, resp_cycles);
		if (!saw_rvv)
			failure("pcpi_is_rvv_o low for a vector instruction");
		if (req_log.size() != first)
			failure("memory request issued for a trapped instruction");
	endtask

	task automatic end_test(input string name, input int start);
		tests_run++;
		if (errors == start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - start);
		end
	endtask

	task automatic config_tests();
		int start, first;
		start = errors;
		issue(vsetvli_insn(11'h011), 32'd5, 32'd0, LIMIT); // e32, m2 gives vlmax 8
		config_result(5);
		issue(vsetvli_insn(11'h011), 32'd100, 32'd0, LIMIT);
		config_result(8);
		issue(vsetivli_insn(5'd3, 10'h000), 32'd0, 32'd0, LIMIT);
		config_result(3);
		end_test("vsetvli", start);
		start = errors;
		issue(vsetvl_insn(), 32'd16, 32'h0000_0004, LIMIT); // reserved lmul
		config_result(0);
		first = req_log.size();
		issue(vmem_insn(1'b0, 3'b110, 5'd2), 32'h40, 32'd0, LIMIT);
		trap_result(first);
		end_test("illegal config", start);
	endtask

	task automatic word_round_trip();
		int start, first;
		start = errors;
		for (int i = 0; i < 32; i++)
			u_mem.mem_bytes[8'h40 + i] <= 8'(i * 7 + 3);
		issue(vsetvli_insn(11'h011), 32'd8, 32'd0, LIMIT);
		config_result(8);
		first = req_log.size();
		issue(vmem_insn(1'b0, 3'b110, 5'd2), 32'h40, 32'd0, LIMIT);
		mem_result(8, first, 1'b0, 32'h40, 4);
		first = req_log.size();
		issue(vmem_insn(1'b1, 3'b110, 5'd2), 32'h80, 32'd0, LIMIT);
		mem_result(8, first, 1'b1, 32'h80, 4);
		for (int i = 0; i < 32; i++) begin
			if (u_mem.mem_bytes[8'h80 + i] !== 8'(i * 7 + 3))
				mismatch($sformatf("mem[%0h]", 8'h80 + i), 8'(i * 7 + 3), u_mem.mem_bytes[8'h80 + i]);
		end
		end_test("word round trip", start);
	endtask

	task automatic byte_stores();
		int start, first;
		logic [7:0] src [5];
		mem_req_t r;
		start = errors;
		issue(vsetivli_insn(5'd5, 10'h000), 32'd0, 32'd0, LIMIT);
		config_result(5);
		first = req_log.size();
		issue(vmem_insn(1'b0, 3'b000, 5'd4), 32'h10, 32'd0, LIMIT);
		mem_result(5, first, 1'b0, 32'h10, 1);
		for (int i = 0; i < 5; i++)
			src[i] = u_mem.mem_bytes[16 + i];
		for (int a = 0; a < 256; a++)
			u_mem.written[a] <= 1'b0;
		first = req_log.size();
		issue(vmem_insn(1'b1, 3'b000, 5'd4), 32'h23, 32'd0, LIMIT);
		mem_result(5, first, 1'b1, 32'h23, 1);
		for (int i = first; i < req_log.size(); i++) begin
			r = req_log[i];
			if (r.strb != 4'b0001 << r.addr[1:0])
				mismatch("mem_req_data_o.strb", 4'b0001 << r.addr[1:0], r.strb);
		end
		for (int a = 0; a < 256; a++) begin
			if (u_mem.written[a] != (a >= 'h23 && a <= 'h27))
				failure($sformatf("byte %0h written flag is wrong", a));
			else if (u_mem.written[a] && u_mem.mem_bytes[a] !== src[a - 'h23])
				mismatch($sformatf("mem[%0h]", a), src[a - 'h23], u_mem.mem_bytes[a]);
		end
		end_test("byte stores", start);
	endtask

	task automatic trap_cases();
		int start, first;
		start = errors;
		issue(vsetvli_insn(11'h011), 32'd8, 32'd0, LIMIT);
		config_result(8);
		first = req_log.size();
		issue(vmem_insn(1'b0, 3'b110, 5'd31), 32'h40, 32'd0, LIMIT); // group past v31
		trap_result(first);
		first = req_log.size();
		issue(vmem_insn(1'b0, 3'b101, 5'd4), 32'h41, 32'd0, LIMIT); // odd address at e16
		trap_result(first);
		end_test("traps", start);
		start = errors;
		first = req_log.size();
		issue(32'h0031_00b3, 32'd1, 32'd2, 10); // add x1, x2, x3
		if (saw_rvv)
			failure("pcpi_is_rvv_o high for a scalar instruction");
		if (got_ready || got_trap || req_log.size() != first)
			failure("scalar instruction got a response from the coprocessor");
		end_test("non-vector", start);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		resetn = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn = '0;
		pcpi_rs1 = '0;
		pcpi_rs2 = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		config_tests();
		word_round_trip();
		byte_stores();
		trap_cases();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: src/rvv_config.sv
module rvv_config (
	input logic clk,
	input logic resetn,
	input logic start_i,
	input rvv_pkg::rvv_dec_t dec_i,
	input logic [31:0] rs1_i,
	input logic [31:0] rs2_i,
	output rvv_pkg::rvv_cfg_t cfg_o,
	output logic [31:0] vl_o
);
	import rvv_pkg::*;

	logic [31:0] vtype_q;
	logic [31:0] vl_q;
	logic [7:0] vtype_new;
	logic reserved_set;
	logic [31:0] vlmax_new;
	logic [31:0] vlmax_cur;
	logic [31:0] avl;
	logic illegal;

	// VLEN/SEW scaled by LMUL, 0 for reserved codes
	function automatic logic [31:0] vlmax_of(input logic [2:0] sew, input logic [2:0] lmul);
		logic [31:0] base;
		base = (sew > 3'd2) ? 32'd0 : 32'(VLEN >> (sew + 3));
		if (lmul == 3'd4)
			return 32'd0;
		else if (lmul[2])
			return base >> (4'd8 - {1'b0, lmul}); // fractional lmul
		else
			return base << lmul;
	endfunction

	always_comb begin
		vtype_new = (dec_i.op == OP_VSETVL) ? rs2_i[7:0] : dec_i.vtype_imm[7:0];
		reserved_set = (dec_i.op == OP_VSETVL) ? |rs2_i[31:8] : |dec_i.vtype_imm[10:8];
		vlmax_new = vlmax_of(vtype_new[5:3], vtype_new[2:0]);
		illegal = vlmax_new == 32'd0 || reserved_set;

		if (dec_i.op == OP_VSETIVLI)
			avl = {27'b0, dec_i.imm};
		else if (dec_i.rs1_nz)
			avl = rs1_i;
		else if (dec_i.rd_nz)
			avl = '1; // request vlmax
		else
			avl = vl_q;

		vl_o = illegal ? 32'd0 : ((avl < vlmax_new) ? avl : vlmax_new);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= VILL_VTYPE;
			vl_q <= '0;
		end else if (start_i) begin
			vtype_q <= illegal ? VILL_VTYPE : {24'b0, vtype_new};
			vl_q <= vl_o;
		end
	end

	assign cfg_o.vill = vtype_q[31];
	assign cfg_o.vma = vtype_q[7];
	assign cfg_o.vta = vtype_q[6];
	assign cfg_o.vsew = (vtype_q[5:3] > 3'd2) ? SEW_RSVD : vsew_e'(vtype_q[5:3]);
	assign cfg_o.vlmul = vtype_q[2:0];
	assign cfg_o.vl = vl_q;

	assign vlmax_cur = vlmax_of(vtype_q[5:3], vtype_q[2:0]);

	vl_within_vlmax: assert property (@(posedge clk) disable iff (!resetn) vl_q <= vlmax_cur);

endmodule

// File: src/rvv_coproc.sv
module rvv_coproc (
	input logic clk,
	input logic resetn,
	input logic pcpi_valid_i,
	input logic [31:0] pcpi_insn_i,
	input logic [31:0] pcpi_rs1_i,
	input logic [31:0] pcpi_rs2_i,
	output logic pcpi_wr_o,
	output logic [31:0] pcpi_rd_o,
	output logic pcpi_wait_o,
	output logic pcpi_ready_o,
	output logic pcpi_trap_o,
	output logic pcpi_is_rvv_o,
	output logic mem_req_o,
	output rvv_pkg::mem_req_t mem_req_data_o,
	input logic mem_done_i,
	input logic [31:0] mem_rdata_i,
	output logic mem_op_o
);
	import rvv_pkg::*;

	rvv_dec_t dec;
	rvv_cfg_t cfg;
	logic [31:0] new_vl;
	logic is_cfg, is_mem;
	logic idle, start;
	logic cfg_start, lsu_start;
	logic lsu_busy, lsu_done;
	logic [4:0] vrf_reg;
	logic [3:0] vrf_elem;
	logic vrf_wr_en;
	logic [31:0] vrf_wr_data, vrf_rd_data;

	assign is_cfg = dec.op inside {OP_VSETVLI, OP_VSETIVLI, OP_VSETVL};
	assign is_mem = dec.op inside {OP_VLOAD, OP_VSTORE};
	assign idle = !lsu_busy && !pcpi_ready_o && !pcpi_trap_o; // valid still high in ready cycle
	assign start = pcpi_valid_i && idle && !dec.trap;
	assign cfg_start = start && is_cfg;
	assign lsu_start = start && is_mem;

	assign pcpi_is_rvv_o = dec.op != OP_NONE;
	assign pcpi_wait_o = lsu_busy;
	assign mem_op_o = lsu_busy;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o <= 1'b0;
			pcpi_trap_o <= 1'b0;
		end else begin
			pcpi_ready_o <= cfg_start || lsu_done;
			pcpi_wr_o <= cfg_start;
			pcpi_trap_o <= pcpi_valid_i && idle && dec.trap;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_start)
			pcpi_rd_o <= new_vl;
	end

	rvv_decoder u_decoder (.insn_i(pcpi_insn_i), .rs1_i(pcpi_rs1_i), .cfg_i(cfg), .dec_o(dec));

	rvv_config u_config (.clk(clk), .resetn(resetn), .start_i(cfg_start), .dec_i(dec),
		.rs1_i(pcpi_rs1_i), .rs2_i(pcpi_rs2_i), .cfg_o(cfg), .vl_o(new_vl));

	rvv_vregfile u_vregfile (.clk(clk), .resetn(resetn), .rd_reg_i(vrf_reg),
		.rd_elem_i(vrf_elem), .sew_i(dec.eew), .rd_data_o(vrf_rd_data), .wr_en_i(vrf_wr_en),
		.wr_reg_i(vrf_reg), .wr_elem_i(vrf_elem), .wr_data_i(vrf_wr_data));

	rvv_lsu u_lsu (.clk(clk), .resetn(resetn), .start_i(lsu_start), .dec_i(dec), .cfg_i(cfg),
		.rs1_i(pcpi_rs1_i), .vrf_rd_data_i(vrf_rd_data), .vrf_reg_o(vrf_reg),
		.vrf_elem_o(vrf_elem), .vrf_wr_en_o(vrf_wr_en), .vrf_wr_data_o(vrf_wr_data),
		.mem_done_i(mem_done_i), .mem_rdata_i(mem_rdata_i), .mem_req_o(mem_req_o),
		.mem_req_data_o(mem_req_data_o), .busy_o(lsu_busy), .done_o(lsu_done));

endmodule

// File: src/rvv_decoder.sv
module rvv_decoder (
	input logic [31:0] insn_i,
	input logic [31:0] rs1_i,
	input rvv_pkg::rvv_cfg_t cfg_i,
	output rvv_pkg::rvv_dec_t dec_o
);
	import rvv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic is_mem;
	logic [35:0] group_bytes;
	logic [35:0] group_regs;
	logic group_over;
	logic misaligned;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];

	always_comb begin
		dec_o = '0;
		dec_o.op = OP_NONE;
		dec_o.eew = SEW_8;
		dec_o.vd = insn_i[11:7];
		dec_o.rd_nz = insn_i[11:7] != 5'd0;
		dec_o.rs1_nz = insn_i[19:15] != 5'd0;
		dec_o.imm = insn_i[19:15];
		// vsetivli has only a 10-bit zimm
		dec_o.vtype_imm = insn_i[31] ? {1'b0, insn_i[29:20]} : insn_i[30:20];

		if (opcode == OPC_V && funct3 == 3'b111) begin
			if (!insn_i[31])
				dec_o.op = OP_VSETVLI;
			else if (insn_i[31:30] == 2'b11)
				dec_o.op = OP_VSETIVLI;
			else if (insn_i[31:25] == 7'b1000000)
				dec_o.op = OP_VSETVL;
		end

		// unit-stride only: nf = 0, mop = 0, lumop/sumop = 0
		if ((opcode == OPC_LOAD_FP || opcode == OPC_STORE_FP) && insn_i[31:29] == 3'd0 &&
				insn_i[27:26] == 2'b00 && insn_i[24:20] == 5'd0) begin
			case (funct3)
				3'b000: dec_o.eew = SEW_8;
				3'b101: dec_o.eew = SEW_16;
				3'b110: dec_o.eew = SEW_32;
				default: dec_o.eew = SEW_RSVD;
			endcase
			if (dec_o.eew != SEW_RSVD)
				dec_o.op = insn_i[5] ? OP_VSTORE : OP_VLOAD;
			else
				dec_o.eew = SEW_8;
		end

		dec_o.trap = is_mem && (cfg_i.vill || group_over || misaligned);
	end

	assign is_mem = dec_o.op == OP_VLOAD || dec_o.op == OP_VSTORE;

	// registers spanned by vl elements, rounded up
	assign group_bytes = {4'b0, cfg_i.vl} << dec_o.eew;
	assign group_regs = (group_bytes + 36'(VLENB - 1)) / 36'(VLENB);
	assign group_over = ({31'b0, dec_o.vd} + group_regs) > 36'(NUM_VREGS);

	assign misaligned = (dec_o.eew == SEW_16 && rs1_i[0]) ||
		(dec_o.eew == SEW_32 && rs1_i[1:0] != 2'b00);

	always_comb begin
		if (!(opcode inside {OPC_V, OPC_LOAD_FP, OPC_STORE_FP}))
			assert (dec_o.op == OP_NONE)
				else $error("rvv_decoder: vector op from a non-vector opcode");
	end

endmodule

// File: src/rvv_lsu.sv
module rvv_lsu (
	input logic clk,
	input logic resetn,
	input logic start_i,
	input rvv_pkg::rvv_dec_t dec_i,
	input rvv_pkg::rvv_cfg_t cfg_i,
	input logic [31:0] rs1_i,
	input logic [31:0] vrf_rd_data_i,
	output logic [4:0] vrf_reg_o,
	output logic [3:0] vrf_elem_o,
	output logic vrf_wr_en_o,
	output logic [31:0] vrf_wr_data_o,
	input logic mem_done_i,
	input logic [31:0] mem_rdata_i,
	output logic mem_req_o,
	output rvv_pkg::mem_req_t mem_req_data_o,
	output logic busy_o,
	output logic done_o
);
	import rvv_pkg::*;

	lsu_state_e state_q;
	logic [31:0] elem_q; // element being transferred
	logic [31:0] byte_off;
	logic [31:0] addr;
	logic [4:0] lane_shift;
	logic [3:0] elem_strb;
	logic is_store;
	logic last_elem;
	logic xfer_done;
	logic req_pending_q;

	assign is_store = dec_i.op == OP_VSTORE;
	assign byte_off = elem_q << dec_i.eew;
	assign addr = rs1_i + byte_off;
	assign lane_shift = {addr[1:0], 3'b000};
	assign last_elem = elem_q == cfg_i.vl - 32'd1;
	assign xfer_done = state_q == LSU_WAIT && mem_done_i;

	// register group offset and index within that register
	assign vrf_reg_o = dec_i.vd + 5'(byte_off >> $clog2(VLENB));
	assign vrf_elem_o = byte_off[3:0] >> dec_i.eew;

	always_comb begin
		case (dec_i.eew)
			SEW_8: elem_strb = 4'b0001;
			SEW_16: elem_strb = 4'b0011;
			default: elem_strb = 4'b1111;
		endcase
	end

	assign mem_req_o = state_q == LSU_REQ;
	assign mem_req_data_o.addr = addr;
	assign mem_req_data_o.wdata = vrf_rd_data_i << lane_shift; // element into its byte lanes
	assign mem_req_data_o.strb = elem_strb << addr[1:0];
	assign mem_req_data_o.store = is_store;

	assign vrf_wr_en_o = xfer_done && !is_store;
	assign vrf_wr_data_o = mem_rdata_i >> lane_shift;

	assign busy_o = state_q != LSU_IDLE;
	assign done_o = state_q == LSU_FINISH || (xfer_done && last_elem);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= LSU_IDLE;
			elem_q <= '0;
		end else begin
			case (state_q)
				LSU_IDLE: begin
					if (start_i) begin
						elem_q <= '0;
						state_q <= (cfg_i.vl == 32'd0) ? LSU_FINISH : LSU_REQ;
					end
				end
				LSU_REQ: state_q <= LSU_WAIT;
				LSU_WAIT: begin
					if (mem_done_i) begin
						if (last_elem) begin
							state_q <= LSU_IDLE;
						end else begin
							elem_q <= elem_q + 32'd1;
							state_q <= LSU_REQ;
						end
					end
				end
				LSU_FINISH: state_q <= LSU_IDLE; // empty vector, report done
				default: state_q <= LSU_IDLE;
			endcase
		end
	end

	// tracks the request that the memory has not answered yet
	always_ff @(posedge clk) begin
		if (!resetn)
			req_pending_q <= 1'b0;
		else if (mem_req_o)
			req_pending_q <= 1'b1;
		else if (mem_done_i)
			req_pending_q <= 1'b0;
	end

	one_outstanding: assert property (@(posedge clk) disable iff (!resetn)
		mem_req_o |-> !req_pending_q);

endmodule

// File: src/rvv_pkg.sv
package rvv_pkg;

	localparam int VLEN = 128;
	localparam int VLENB = VLEN / 8;
	localparam int NUM_VREGS = 32;

	localparam logic [31:0] VILL_VTYPE = 32'h8000_0000; // only vill set

	localparam logic [6:0] OPC_V = 7'b1010111;
	localparam logic [6:0] OPC_LOAD_FP = 7'b0000111;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

	typedef enum logic [2:0] {
		OP_NONE = 3'd0,
		OP_VSETVLI = 3'd1,
		OP_VSETIVLI = 3'd2,
		OP_VSETVL = 3'd3,
		OP_VLOAD = 3'd4,
		OP_VSTORE = 3'd5
	} rvv_op_e;

	// vtype.vsew encoding, 64-bit and above folded into reserved
	typedef enum logic [2:0] {
		SEW_8 = 3'd0,
		SEW_16 = 3'd1,
		SEW_32 = 3'd2,
		SEW_RSVD = 3'd3
	} vsew_e;

	typedef struct packed {
		logic vill;
		logic vma;
		logic vta;
		vsew_e vsew;
		logic [2:0] vlmul;
		logic [31:0] vl;
	} rvv_cfg_t;

	typedef struct packed {
		rvv_op_e op;
		logic [4:0] vd;
		logic rs1_nz; // rs1 field non-zero
		logic rd_nz; // rd field non-zero
		logic [4:0] imm; // uimm of vsetivli
		logic [10:0] vtype_imm; // zimm of vsetvli / vsetivli
		vsew_e eew; // element width of a memory op
		logic trap;
	} rvv_dec_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] strb;
		logic store;
	} mem_req_t;

	typedef enum logic [1:0] {
		LSU_IDLE = 2'd0,
		LSU_REQ = 2'd1,
		LSU_WAIT = 2'd2,
		LSU_FINISH = 2'd3
	} lsu_state_e;

endpackage

// File: src/rvv_vregfile.sv
module rvv_vregfile (
	input logic clk,
	input logic resetn,
	input logic [4:0] rd_reg_i,
	input logic [3:0] rd_elem_i,
	input rvv_pkg::vsew_e sew_i,
	output logic [31:0] rd_data_o,
	input logic wr_en_i,
	input logic [4:0] wr_reg_i,
	input logic [3:0] wr_elem_i,
	input logic [31:0] wr_data_i
);
	import rvv_pkg::*;

	logic [VLEN-1:0] vregs [NUM_VREGS];
	logic [3:0] rd_byte;
	logic [3:0] wr_byte;
	logic [VLEN-1:0] rd_word;
	logic [VLEN-1:0] elem_mask;
	logic [VLEN-1:0] wr_mask;
	logic [VLEN-1:0] wr_word;

	assign rd_byte = rd_elem_i << sew_i;
	assign wr_byte = wr_elem_i << sew_i;

	always_comb begin
		case (sew_i)
			SEW_8: elem_mask = VLEN'(32'h0000_00ff);
			SEW_16: elem_mask = VLEN'(32'h0000_ffff);
			default: elem_mask = VLEN'(32'hffff_ffff);
		endcase
	end

	assign rd_word = vregs[rd_reg_i] >> {rd_byte, 3'b000};
	assign rd_data_o = rd_word[31:0] & elem_mask[31:0]; // zero-extended element

	assign wr_mask = elem_mask << {wr_byte, 3'b000};
	assign wr_word = VLEN'(wr_data_i) << {wr_byte, 3'b000};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < NUM_VREGS; i++)
				vregs[i] <= '0;
		end else if (wr_en_i) begin
			vregs[wr_reg_i] <= (vregs[wr_reg_i] & ~wr_mask) | (wr_word & wr_mask);
		end
	end

endmodule

// File: vlog.f
src/rvv_pkg.sv
src/rvv_decoder.sv
src/rvv_config.sv
src/rvv_vregfile.sv
src/rvv_lsu.sv
src/rvv_coproc.sv
dv/tb_mem_model.sv
dv/tb_rvv.sv
